//--- include/alu_macros.svh
// Widths, instruction field positions and opcode values for the RV32I ALU.
// Included by the package and by any module that slices the instruction word.
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Data and register file widths
`define ALU_XLEN            32
`define ALU_REG_ADDR_W      5
`define ALU_SHAMT_W         5
`define ALU_INST_W          32

// Instruction field positions
`define ALU_OPCODE_LSB      0
`define ALU_RD_LSB          7
`define ALU_FUNCT3_LSB      12
`define ALU_RS1_LSB         15
`define ALU_RS2_LSB         20
`define ALU_IMM_LSB         20
`define ALU_OPCODE_W        7
`define ALU_FUNCT3_W        3
`define ALU_IMM_W           12

// Subtract or arithmetic shift select
`define ALU_ALT_BIT         30

// Major opcodes
`define ALU_OPC_I_ARITH     7'b0010011
`define ALU_OPC_R_ARITH     7'b0110011

// funct3 codes, shared by both groups
`define ALU_F3_ADD          3'b000
`define ALU_F3_SLL          3'b001
`define ALU_F3_SLT          3'b010
`define ALU_F3_SLTU         3'b011
`define ALU_F3_XOR          3'b100
`define ALU_F3_SR           3'b101
`define ALU_F3_OR           3'b110
`define ALU_F3_AND          3'b111

`endif

//--- verilog/alu_pkg.sv
// Shared types of the ALU: data and index vectors, the operation code
// and the record passed from decode to execute.
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`ALU_XLEN-1:0]       xlen_t;
    typedef logic [`ALU_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ALU_INST_W-1:0]     inst_t;
    typedef logic [`ALU_SHAMT_W-1:0]    shamt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        fn_add,
        fn_sub,
        fn_slt,
        fn_sltu,
        fn_xor,
        fn_or,
        fn_and,
        fn_sll,
        fn_srl,
        fn_sra,
        // Opcode outside the arithmetic groups
        fn_zero
    } alu_fn_t;

    // Decoded operation, 74 bits
    typedef struct packed {
        logic      valid;
        alu_fn_t   fn;
        xlen_t     operand_a;
        xlen_t     operand_b;
        reg_addr_t rd;
    } alu_op_t;

endpackage

`default_nettype wire

//--- verilog/alu_shifter.sv
// Logarithmic barrel shifter for SLL, SRL and SRA; left shifts run through
// the same right-shift network with the word bit-reversed on both sides.
`default_nettype none

`include "alu_macros.svh"

module alu_shifter (
    input  alu_pkg::xlen_t  value,
    input  alu_pkg::shamt_t amount,
    input  logic            right,
    input  logic            arith,
    output alu_pkg::xlen_t  result
);

    alu_pkg::xlen_t stages [0:`ALU_SHAMT_W];
    logic           fill;

    function automatic alu_pkg::xlen_t bit_reverse(input alu_pkg::xlen_t din);
        alu_pkg::xlen_t dout;
        for (int i = 0; i < `ALU_XLEN; i++) begin
            dout[i] = din[`ALU_XLEN-1-i];
        end
        return dout;
    endfunction

    // Sign fill only for arithmetic right shifts
    assign fill = right & arith & value[`ALU_XLEN-1];

    assign stages[0] = right ? value : bit_reverse(value);

    // One level per amount bit, shifting by 1, 2, 4, 8 then 16
    for (genvar lvl = 0; lvl < `ALU_SHAMT_W; lvl++) begin : g_level
        localparam int STEP = 1 << lvl;
        assign stages[lvl+1] = amount[lvl] ?
                               {{STEP{fill}}, stages[lvl][`ALU_XLEN-1:STEP]} :
                               stages[lvl];
    end

    assign result = right ? stages[`ALU_SHAMT_W] : bit_reverse(stages[`ALU_SHAMT_W]);

endmodule

`default_nettype wire

//--- verilog/alu_decode.sv
// Instruction decode: drives the register file addresses and turns the
// instruction word and operand values into one operation record.
`default_nettype none

`include "alu_macros.svh"

module alu_decode (
    input  logic               alu_valid,
    input  alu_pkg::inst_t     alu_instbus,
    input  alu_pkg::xlen_t     alu_rs1_val,
    input  alu_pkg::xlen_t     alu_rs2_val,
    output alu_pkg::reg_addr_t alu_rs1_addr,
    output alu_pkg::reg_addr_t alu_rs2_addr,
    output alu_pkg::alu_op_t   op
);

    logic [`ALU_OPCODE_W-1:0] opcode;
    logic [`ALU_FUNCT3_W-1:0] funct3;
    logic [`ALU_IMM_W-1:0]    imm12;
    logic                     alt;
    logic                     is_imm;
    logic                     is_reg;
    alu_pkg::xlen_t           imm_sext;
    alu_pkg::alu_fn_t         fn;

    ////////////////////////////////////////////////////////////////////////////
    // Fields
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = alu_instbus[`ALU_OPCODE_LSB +: `ALU_OPCODE_W];
    assign funct3 = alu_instbus[`ALU_FUNCT3_LSB +: `ALU_FUNCT3_W];
    assign imm12  = alu_instbus[`ALU_IMM_LSB +: `ALU_IMM_W];
    assign alt    = alu_instbus[`ALU_ALT_BIT];

    assign is_imm = (opcode == `ALU_OPC_I_ARITH);
    assign is_reg = (opcode == `ALU_OPC_R_ARITH);

    // Low five bits double as shamt for the immediate shifts
    assign imm_sext = {{(`ALU_XLEN-`ALU_IMM_W){imm12[`ALU_IMM_W-1]}}, imm12};

    assign alu_rs1_addr = alu_instbus[`ALU_RS1_LSB +: `ALU_REG_ADDR_W];
    assign alu_rs2_addr = alu_instbus[`ALU_RS2_LSB +: `ALU_REG_ADDR_W];

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        fn = alu_pkg::fn_zero;
        if (is_imm || is_reg) begin
            case (funct3)
                // No SUBI, so bit 30 only matters for the register form
                `ALU_F3_ADD:  fn = (is_reg && alt) ? alu_pkg::fn_sub : alu_pkg::fn_add;
                `ALU_F3_SLL:  fn = alu_pkg::fn_sll;
                `ALU_F3_SLT:  fn = alu_pkg::fn_slt;
                `ALU_F3_SLTU: fn = alu_pkg::fn_sltu;
                `ALU_F3_XOR:  fn = alu_pkg::fn_xor;
                `ALU_F3_SR:   fn = alt ? alu_pkg::fn_sra : alu_pkg::fn_srl;
                `ALU_F3_OR:   fn = alu_pkg::fn_or;
                `ALU_F3_AND:  fn = alu_pkg::fn_and;
                default:      fn = alu_pkg::fn_zero;
            endcase
        end
    end

    assign op.valid     = alu_valid;
    assign op.fn        = fn;
    assign op.operand_a = alu_rs1_val;
    assign op.operand_b = is_imm ? imm_sext : alu_rs2_val;
    assign op.rd        = alu_instbus[`ALU_RD_LSB +: `ALU_REG_ADDR_W];

endmodule

`default_nettype wire

//--- verilog/alu_execute.sv
// Execute stage: computes the result of the decoded operation and registers
// the destination write, one cycle after the strobe.
`default_nettype none

module alu_execute (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               srst,
    input  alu_pkg::alu_op_t   op,
    output logic               alu_rd_wr,
    output alu_pkg::reg_addr_t alu_rd_addr,
    output alu_pkg::xlen_t     alu_rd_val
);

    alu_pkg::xlen_t  sum;
    alu_pkg::xlen_t  diff;
    alu_pkg::xlen_t  shifted;
    alu_pkg::xlen_t  result;
    alu_pkg::shamt_t shift_amount;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            shift_right;
    logic            shift_arith;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    assign sum         = op.operand_a + op.operand_b;
    assign diff        = op.operand_a - op.operand_b;
    assign lt_signed   = $signed(op.operand_a) < $signed(op.operand_b);
    assign lt_unsigned = op.operand_a < op.operand_b;

    // Shift amount is shamt or rs2[4:0], both sit in the low bits of operand b
    assign shift_amount = alu_pkg::shamt_t'(op.operand_b);
    assign shift_right  = (op.fn == alu_pkg::fn_srl) || (op.fn == alu_pkg::fn_sra);
    assign shift_arith  = (op.fn == alu_pkg::fn_sra);

    alu_shifter i_alu_shifter (
        .value  (op.operand_a),
        .amount (shift_amount),
        .right  (shift_right),
        .arith  (shift_arith),
        .result (shifted)
    );

    always_comb begin
        case (op.fn)
            alu_pkg::fn_add:  result = sum;
            alu_pkg::fn_sub:  result = diff;
            alu_pkg::fn_slt:  result = alu_pkg::xlen_t'(lt_signed);
            alu_pkg::fn_sltu: result = alu_pkg::xlen_t'(lt_unsigned);
            alu_pkg::fn_xor:  result = op.operand_a ^ op.operand_b;
            alu_pkg::fn_or:   result = op.operand_a | op.operand_b;
            alu_pkg::fn_and:  result = op.operand_a & op.operand_b;
            alu_pkg::fn_sll,
            alu_pkg::fn_srl,
            alu_pkg::fn_sra:  result = shifted;
            default:          result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            alu_rd_wr   <= 1'b0;
            alu_rd_addr <= '0;
            alu_rd_val  <= '0;
        end else if (srst) begin
            alu_rd_wr   <= 1'b0;
            alu_rd_addr <= '0;
            alu_rd_val  <= '0;
        end else begin
            alu_rd_wr   <= op.valid;
            alu_rd_addr <= op.rd;
            alu_rd_val  <= result;
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_core.sv
// ALU top level: combinational decode feeding the registered execute stage,
// with the register file reached through the rs and rd ports.
`default_nettype none

module alu_core (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               srst,
    // Instruction strobe
    input  logic               alu_valid,
    input  alu_pkg::inst_t     alu_instbus,
    // Source register reads, answered in the same cycle
    output alu_pkg::reg_addr_t alu_rs1_addr,
    input  alu_pkg::xlen_t     alu_rs1_val,
    output alu_pkg::reg_addr_t alu_rs2_addr,
    input  alu_pkg::xlen_t     alu_rs2_val,
    // Destination write
    output logic               alu_rd_wr,
    output alu_pkg::reg_addr_t alu_rd_addr,
    output alu_pkg::xlen_t     alu_rd_val
);

    alu_pkg::alu_op_t op;

    alu_decode i_alu_decode (
        .alu_valid    (alu_valid),
        .alu_instbus  (alu_instbus),
        .alu_rs1_val  (alu_rs1_val),
        .alu_rs2_val  (alu_rs2_val),
        .alu_rs1_addr (alu_rs1_addr),
        .alu_rs2_addr (alu_rs2_addr),
        .op           (op)
    );

    alu_execute i_alu_execute (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .op          (op),
        .alu_rd_wr   (alu_rd_wr),
        .alu_rd_addr (alu_rd_addr),
        .alu_rd_val  (alu_rd_val)
    );

endmodule

`default_nettype wire

//--- dv/alu_checker.sv
// Watches the ALU ports, predicts each destination write from the RV32I rules
// and counts mismatches. Instantiated by the testbench top next to the DUT.
`default_nettype none

module alu_checker (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               srst,
    input  logic               alu_valid,
    input  alu_pkg::inst_t     alu_instbus,
    input  alu_pkg::reg_addr_t alu_rs1_addr,
    input  alu_pkg::xlen_t     alu_rs1_val,
    input  alu_pkg::reg_addr_t alu_rs2_addr,
    input  alu_pkg::xlen_t     alu_rs2_val,
    input  logic               alu_rd_wr,
    input  alu_pkg::reg_addr_t alu_rd_addr,
    input  alu_pkg::xlen_t     alu_rd_val,
    output int                 done_count,
    output int                 value_errors,
    output int                 missing_errors,
    output int                 spurious_errors
);

    alu_pkg::xlen_t     exp_val;
    alu_pkg::reg_addr_t exp_rd;
    string              exp_name;
    string              clear_name;
    logic               pending;
    logic               after_clear;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic alu_pkg::xlen_t expected_result(input alu_pkg::inst_t inst,
                                                       input alu_pkg::xlen_t a,
                                                       input alu_pkg::xlen_t rs2);
        alu_pkg::xlen_t b;
        alu_pkg::xlen_t res;
        logic [4:0]     sh;
        logic           is_imm;
        is_imm = (inst[6:0] == 7'b0010011);
        if (!is_imm && inst[6:0] != 7'b0110011) begin
            return '0;
        end
        // Sign-extended I-type immediate from inst[31:20]
        b   = is_imm ? {{20{inst[31]}}, inst[31:20]} : rs2;
        sh  = b[4:0];
        res = '0;
        case (inst[14:12])
            3'b000: res = (!is_imm && inst[30]) ? a - b : a + b;
            3'b001: res = a << sh;
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (inst[30]) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic string inst_name(input alu_pkg::inst_t inst);
        string name;
        logic  is_imm;
        is_imm = (inst[6:0] == 7'b0010011);
        if (!is_imm && inst[6:0] != 7'b0110011) begin
            return "OTHER_OPC";
        end
        case (inst[14:12])
            3'b000: name = is_imm ? "ADDI" : (inst[30] ? "SUB" : "ADD");
            3'b001: name = is_imm ? "SLLI" : "SLL";
            3'b010: name = is_imm ? "SLTI" : "SLT";
            3'b011: name = is_imm ? "SLTIU" : "SLTU";
            3'b100: name = is_imm ? "XORI" : "XOR";
            3'b101: name = inst[30] ? (is_imm ? "SRAI" : "SRA") : (is_imm ? "SRLI" : "SRL");
            3'b110: name = is_imm ? "ORI" : "OR";
            default: name = is_imm ? "ANDI" : "AND";
        endcase
        return name;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_field(input string test, input string field,
                               input alu_pkg::xlen_t exp, input alu_pkg::xlen_t act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %h actual %h", test, field, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_clear(input string test);
        check_field(test, "alu_rd_wr", '0, alu_pkg::xlen_t'(alu_rd_wr));
        check_field(test, "alu_rd_addr", '0, alu_pkg::xlen_t'(alu_rd_addr));
        check_field(test, "alu_rd_val", '0, alu_rd_val);
    endtask

    task automatic capture_strobe;
        exp_name = inst_name(alu_instbus);
        check_field(exp_name, "alu_rs1_addr", alu_pkg::xlen_t'(alu_instbus[19:15]),
                    alu_pkg::xlen_t'(alu_rs1_addr));
        check_field(exp_name, "alu_rs2_addr", alu_pkg::xlen_t'(alu_instbus[24:20]),
                    alu_pkg::xlen_t'(alu_rs2_addr));
        exp_rd  = alu_instbus[11:7];
        exp_val = expected_result(alu_instbus, alu_rs1_val, alu_rs2_val);
        pending = 1'b1;
    endtask

    task automatic compare_write;
        done_count++;
        if (alu_rd_wr !== 1'b1) begin
            $display("%s write missing: alu_rd_wr not high one cycle after the strobe",
                     exp_name);
            missing_errors++;
        end else begin
            check_field(exp_name, "alu_rd_addr", alu_pkg::xlen_t'(exp_rd),
                        alu_pkg::xlen_t'(alu_rd_addr));
            check_field(exp_name, "alu_rd_val", exp_val, alu_rd_val);
        end
    endtask

    initial begin
        done_count      = 0;
        value_errors    = 0;
        missing_errors  = 0;
        spurious_errors = 0;
        pending         = 1'b0;
        after_clear     = 1'b0;
        clear_name      = "reset";
    end

    // Outputs seen here are the ones registered on the previous edge
    always @(posedge aclk) begin
        if (!aresetn) begin
            // Async clear at time zero is only certain after the first edge
            if (after_clear) begin
                check_clear("reset");
            end
            pending     = 1'b0;
            after_clear = 1'b1;
            clear_name  = "reset";
        end else begin
            if (after_clear) begin
                check_clear(clear_name);
            end else if (pending) begin
                compare_write();
            end else if (alu_rd_wr !== 1'b0) begin
                $display("spurious write to x%0d with no strobe the cycle before",
                         alu_rd_addr);
                spurious_errors++;
            end
            pending     = 1'b0;
            after_clear = srst;
            clear_name  = "srst";
            if (alu_valid && !srst) begin
                capture_strobe();
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_alu_core.sv
// Testbench top for the ALU with clock, reset, register file model and RV32I
// instruction stimulus. The checker module does all comparing.
`default_nettype none

`include "alu_macros.svh"

module tb_alu_core;

    localparam int WAIT_LIMIT = 1000;

    logic               aclk;
    logic               aresetn;
    logic               srst;
    logic               alu_valid;
    alu_pkg::inst_t     alu_instbus;
    alu_pkg::reg_addr_t alu_rs1_addr;
    alu_pkg::reg_addr_t alu_rs2_addr;
    alu_pkg::xlen_t     alu_rs1_val;
    alu_pkg::xlen_t     alu_rs2_val;
    logic               alu_rd_wr;
    alu_pkg::reg_addr_t alu_rd_addr;
    alu_pkg::xlen_t     alu_rd_val;

    alu_pkg::xlen_t regs [0:31];
    int             seed;
    int             issued;
    int             done_count;
    int             value_errors;
    int             missing_errors;
    int             spurious_errors;

    // Register file model where x0 reads as zero
    assign alu_rs1_val = (alu_rs1_addr == '0) ? '0 : regs[alu_rs1_addr];
    assign alu_rs2_val = (alu_rs2_addr == '0) ? '0 : regs[alu_rs2_addr];

    alu_core i_alu_core (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .srst         (srst),
        .alu_valid    (alu_valid),
        .alu_instbus  (alu_instbus),
        .alu_rs1_addr (alu_rs1_addr),
        .alu_rs1_val  (alu_rs1_val),
        .alu_rs2_addr (alu_rs2_addr),
        .alu_rs2_val  (alu_rs2_val),
        .alu_rd_wr    (alu_rd_wr),
        .alu_rd_addr  (alu_rd_addr),
        .alu_rd_val   (alu_rd_val)
    );

    alu_checker i_alu_checker (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .srst            (srst),
        .alu_valid       (alu_valid),
        .alu_instbus     (alu_instbus),
        .alu_rs1_addr    (alu_rs1_addr),
        .alu_rs1_val     (alu_rs1_val),
        .alu_rs2_addr    (alu_rs2_addr),
        .alu_rs2_val     (alu_rs2_val),
        .alu_rd_wr       (alu_rd_wr),
        .alu_rd_addr     (alu_rd_addr),
        .alu_rd_val      (alu_rd_val),
        .done_count      (done_count),
        .value_errors    (value_errors),
        .missing_errors  (missing_errors),
        .spurious_errors (spurious_errors)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    function automatic alu_pkg::inst_t imm_inst(input logic [2:0] f3,
                                                input alu_pkg::reg_addr_t rd,
                                                input alu_pkg::reg_addr_t rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, f3, rd, `ALU_OPC_I_ARITH};
    endfunction

    function automatic alu_pkg::inst_t reg_inst(input logic [2:0] f3, input logic alt,
                                                input alu_pkg::reg_addr_t rd,
                                                input alu_pkg::reg_addr_t rs1,
                                                input alu_pkg::reg_addr_t rs2);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, `ALU_OPC_R_ARITH};
    endfunction

    // Called right after a falling edge
    task automatic present(input alu_pkg::inst_t inst);
        alu_valid   = 1'b1;
        alu_instbus = inst;
        issued++;
    endtask

    initial begin
        logic [31:0] pick;
        logic [2:0]  f3;
        int          idx;
        int          a;
        int          b;
        int          cycles;

        seed        = 32'h2143320d;
        aresetn     = 1'b0;
        srst        = 1'b0;
        alu_valid   = 1'b0;
        alu_instbus = '0;
        issued      = 0;
        for (idx = 0; idx < 32; idx++) begin
            regs[idx] = $random(seed);
        end
        // Extremes for the signed compares and the sign fill
        regs[1] = 32'h8000_0000;
        regs[2] = 32'h7fff_ffff;
        regs[3] = 32'hffff_ffff;

        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        ////////////////////////////////////////////////////////////////////////
        // Arithmetic, logic and compares, back to back
        ////////////////////////////////////////////////////////////////////////

        for (idx = 0; idx < 60; idx++) begin
            pick = $random(seed);
            f3   = pick[2:0];
            if (f3 == `ALU_F3_SLL || f3 == `ALU_F3_SR) begin
                f3 = f3 ^ 3'b010;
            end
            @(negedge aclk);
            present(imm_inst(f3, pick[7:3], pick[12:8], pick[24:13]));
        end
        for (idx = 0; idx < 60; idx++) begin
            pick = $random(seed);
            f3   = pick[2:0];
            if (f3 == `ALU_F3_SLL || f3 == `ALU_F3_SR) begin
                f3 = f3 ^ 3'b010;
            end
            @(negedge aclk);
            present(reg_inst(f3, pick[3] && (f3 == `ALU_F3_ADD), pick[8:4], pick[13:9],
                             pick[18:14]));
        end
        for (a = 0; a < 4; a++) begin
            for (b = 0; b < 4; b++) begin
                @(negedge aclk);
                present(reg_inst(`ALU_F3_SLT, 1'b0, 5'd10, a[4:0], b[4:0]));
                @(negedge aclk);
                present(reg_inst(`ALU_F3_SLTU, 1'b0, 5'd11, a[4:0], b[4:0]));
            end
        end

        // Synchronous clear between bursts drops the strobe under it
        @(negedge aclk);
        alu_instbus = reg_inst(`ALU_F3_OR, 1'b0, 5'd12, 5'd1, 5'd2);
        srst        = 1'b1;
        @(negedge aclk);
        alu_valid   = 1'b0;
        srst        = 1'b0;

        ////////////////////////////////////////////////////////////////////////
        // Shifts over every amount
        ////////////////////////////////////////////////////////////////////////

        for (idx = 0; idx < 32; idx++) begin
            pick = $random(seed);
            @(negedge aclk);
            present(imm_inst(`ALU_F3_SLL, pick[4:0], pick[9:5], {7'b0000000, idx[4:0]}));
            @(negedge aclk);
            present(imm_inst(`ALU_F3_SR, pick[14:10], pick[9:5], {7'b0000000, idx[4:0]}));
            @(negedge aclk);
            present(imm_inst(`ALU_F3_SR, pick[19:15], idx[0] ? 5'd1 : 5'd3,
                             {7'b0100000, idx[4:0]}));
            // Upper bits of rs2 are random and must be ignored
            @(negedge aclk);
            regs[5] = {pick[31:5], idx[4:0]};
            present(reg_inst(`ALU_F3_SLL, 1'b0, pick[24:20], pick[9:5], 5'd5));
            @(negedge aclk);
            present(reg_inst(`ALU_F3_SR, 1'b0, pick[29:25], 5'd3, 5'd5));
            @(negedge aclk);
            present(reg_inst(`ALU_F3_SR, 1'b1, pick[4:0], pick[20:16], 5'd5));
        end

        // Loads and branches fall outside both arithmetic groups
        for (idx = 0; idx < 8; idx++) begin
            pick = $random(seed);
            @(negedge aclk);
            present({pick[31:7], idx[0] ? 7'b0000011 : 7'b1100011});
        end

        @(negedge aclk);
        alu_valid   = 1'b0;
        alu_instbus = '0;

        cycles = 0;
        while (done_count < issued && cycles < WAIT_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        if (done_count < issued) begin
            $display("timeout: only %0d of %0d writes seen after %0d cycles",
                     done_count, issued, cycles);
        end else begin
            // Idle cycles to catch late writes
            repeat (4) @(negedge aclk);
        end
        $display("checked %0d writes: value errors %0d, missing writes %0d, spurious writes %0d",
                 done_count, value_errors, missing_errors, spurious_errors);
        if (done_count == issued && value_errors + missing_errors + spurious_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
verilog/alu_pkg.sv
verilog/alu_shifter.sv
verilog/alu_decode.sv
verilog/alu_execute.sv
verilog/alu_core.sv
dv/alu_checker.sv
dv/tb_alu_core.sv
